//--- rtl/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Log2 of the entry count
`define FB_DEPTH 3

// Instruction word width
`define FB_WORD 32

// Prefetch limit in half-words, twice the entries minus 4
`define FB_WINDOW ((2 << `FB_DEPTH) - 4)

`endif

//--- rtl/fetch_pkg.sv
`include "fetch_defs.svh"

package fetch_pkg;

  typedef logic [`FB_WORD-1:0] fetch_word_t;

  typedef struct packed {
    logic        valid;
    logic [29:0] tag;   // Word address bits 31:2
    fetch_word_t data;
  } fb_entry_t;

  typedef enum logic {FB_RUN, FB_FLUSH} fb_state_e;

  typedef enum logic {ILEN_16, ILEN_32} ilen_e;

  // Both low bits set means a full 32-bit instruction
  function automatic ilen_e get_ilen(input logic [15:0] parcel);
    return (&parcel[1:0]) ? ILEN_32 : ILEN_16;
  endfunction

endpackage

//--- rtl/fetch_buffer_ram.sv
`timescale 1ns/100ps
`include "fetch_defs.svh"

module fetch_buffer_ram (
  input  logic                 clk,
  input  logic                 wen,
  input  logic [`FB_DEPTH-1:0] waddr,
  input  fetch_pkg::fb_entry_t wentry,
  input  logic [`FB_DEPTH-1:0] raddr1,
  input  logic [`FB_DEPTH-1:0] raddr2,
  output fetch_pkg::fb_entry_t rentry1,
  output fetch_pkg::fb_entry_t rentry2
);
  import fetch_pkg::*;

  // All entries start out invalid
  fb_entry_t mem [0:(1 << `FB_DEPTH)-1] = '{default: '0};

  always_ff @(posedge clk) begin
    if (wen) begin
      mem[waddr] <= wentry;
    end
  end

  // Two lookups per cycle, word and next word
  assign rentry1 = mem[raddr1];
  assign rentry2 = mem[raddr2];

  a_waddr_known: assert property (@(posedge clk) wen |-> !$isunknown(waddr))
    else $error("fetch_buffer_ram: write with unknown slot address");

endmodule

//--- rtl/fetch_buffer_ctrl.sv
`timescale 1ns/100ps
`include "fetch_defs.svh"

module fetch_buffer_ctrl (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   fetch_valid,
  input  logic                   fetch_fence,
  input  logic [31:0]            fetch_addr,
  output logic                   fetch_ready,
  output fetch_pkg::fetch_word_t fetch_rdata,
  input  logic                   imem_ready,
  input  fetch_pkg::fetch_word_t imem_rdata,
  output logic                   imem_valid,
  output logic                   imem_fence,
  output logic [31:0]            imem_addr,
  output logic                   wen,
  output logic [`FB_DEPTH-1:0]   waddr,
  output fetch_pkg::fb_entry_t   wentry,
  output logic [`FB_DEPTH-1:0]   raddr1,
  output logic [`FB_DEPTH-1:0]   raddr2,
  input  fetch_pkg::fb_entry_t   rentry1,
  input  fetch_pkg::fb_entry_t   rentry2
);
  import fetch_pkg::*;

  localparam int CNT_W = `FB_DEPTH + 1;
  localparam logic [CNT_W-1:0] WINDOW = `FB_WINDOW;

  fb_state_e            state;
  fb_state_e            state_nxt;
  logic [`FB_DEPTH-1:0] fid;       // Slot being cleared
  logic [`FB_DEPTH-1:0] fid_nxt;
  logic [31:0]          addr;      // Next word to prefetch
  logic [31:0]          addr_nxt;
  logic [CNT_W-1:0]     incr;      // Half-words fetched ahead of the core
  logic [CNT_W-1:0]     incr_nxt;

  logic                 lookup;
  logic                 misal;
  logic [29:0]          tag1;
  logic [29:0]          tag2;
  logic                 st_hit1;
  logic                 st_hit2;
  logic                 wr_hit1;
  logic                 wr_hit2;
  logic                 hit1;
  logic                 hit2;
  logic                 st_ready;
  fetch_word_t          word1;
  fetch_word_t          word2;
  ilen_e                len;
  logic [CNT_W-1:0]     step;

  // ##########################################################
  // Store writes, prefetch and flush sequencing
  // ##########################################################

  always_comb begin
    state_nxt = state;
    fid_nxt   = fid;
    wen       = 1'b0;
    waddr     = addr[`FB_DEPTH+1:2];
    wentry    = '0;
    case (state)
      FB_RUN: begin
        if (fetch_valid && fetch_fence) begin
          wen       = 1'b1;    // Slot 0 cleared in the fence cycle
          waddr     = '0;
          fid_nxt   = '0;
          state_nxt = FB_FLUSH;
        end else if (imem_ready) begin
          wen          = 1'b1;
          wentry.valid = 1'b1;
          wentry.tag   = addr[31:2];
          wentry.data  = imem_rdata;
        end
      end
      FB_FLUSH: begin
        if (fid != '1) begin
          wen     = 1'b1;
          waddr   = fid + 1'b1;
          fid_nxt = fid + 1'b1;
        end else if (imem_ready) begin
          state_nxt = FB_RUN;  // Memory has seen the fence
        end
      end
      default: state_nxt = FB_RUN;
    endcase
  end

  // ##########################################################
  // Lookup of the fetch word and the word after it
  // ##########################################################

  assign lookup = fetch_valid && !fetch_fence && (state == FB_RUN);
  assign misal  = fetch_addr[1];
  assign tag1   = fetch_addr[31:2];
  assign tag2   = fetch_addr[31:2] + 30'd1;
  assign raddr1 = tag1[`FB_DEPTH-1:0];
  assign raddr2 = tag2[`FB_DEPTH-1:0];

  assign st_hit1 = rentry1.valid && (rentry1.tag == tag1);
  assign st_hit2 = rentry2.valid && (rentry2.tag == tag2);
  assign wr_hit1 = wen && wentry.valid && (wentry.tag == tag1);  // Bypass
  assign wr_hit2 = wen && wentry.valid && (wentry.tag == tag2);

  assign hit1  = wr_hit1 || st_hit1;
  assign hit2  = wr_hit2 || st_hit2;
  assign word1 = wr_hit1 ? wentry.data : rentry1.data;
  assign word2 = wr_hit2 ? wentry.data : rentry2.data;

  // Built from store contents only so imem_valid never waits on imem_ready
  assign st_ready = lookup && st_hit1 &&
                    (!misal || st_hit2 || get_ilen(rentry1.data[31:16]) == ILEN_16);

  always_comb begin
    fetch_ready = 1'b0;
    fetch_rdata = '0;
    if (lookup && hit1) begin
      if (!misal) begin
        fetch_rdata = word1;
        fetch_ready = 1'b1;
      end else begin
        fetch_rdata[15:0] = word1[31:16];
        fetch_ready       = (get_ilen(word1[31:16]) == ILEN_16);
        if (hit2) begin
          fetch_rdata[31:16] = word2[15:0];  // Upper half from next word
          fetch_ready        = 1'b1;
        end
      end
    end
  end

  assign len  = get_ilen(fetch_rdata[15:0]);
  assign step = (len == ILEN_32) ? CNT_W'(2) : CNT_W'(1);

  // ##########################################################
  // Prefetch address, window count and redirect
  // ##########################################################

  always_comb begin
    addr_nxt = addr;
    incr_nxt = incr;
    if (state == FB_RUN && fetch_valid && fetch_fence) begin
      incr_nxt = '0;
    end else if (wentry.valid) begin
      if (incr < WINDOW) begin
        addr_nxt = addr + 32'd4;
        incr_nxt = incr + CNT_W'(2);
      end
      if (lookup && !fetch_ready) begin
        if (!hit1) begin
          addr_nxt = {tag1, 2'b00};
          incr_nxt = '0;
        end else if (!hit2) begin
          addr_nxt = {tag2, 2'b00};  // Second half of a split instruction
          incr_nxt = '0;
        end
      end
    end
    if (fetch_ready && step <= incr_nxt) begin
      incr_nxt = incr_nxt - step;
    end
  end

  assign imem_valid = (state == FB_FLUSH) || (incr < WINDOW) || (lookup && !st_ready);
  assign imem_fence = (state == FB_FLUSH);
  assign imem_addr  = addr;

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= FB_RUN;
      fid   <= '0;
      addr  <= '0;
      incr  <= '0;
    end else begin
      state <= state_nxt;
      fid   <= fid_nxt;
      addr  <= addr_nxt;
      incr  <= incr_nxt;
    end
  end

  a_imem_addr_hold: assert property (@(posedge clk) disable iff (!rst)
    (imem_valid && !imem_ready) |=> $stable(imem_addr))
    else $error("fetch_buffer_ctrl: imem_addr changed while the memory stalled");

  a_window_bound: assert property (@(posedge clk) disable iff (!rst)
    incr <= WINDOW + CNT_W'(1))
    else $error("fetch_buffer_ctrl: prefetch count beyond the window");

endmodule

//--- rtl/fetch_buffer.sv
`timescale 1ns/100ps
`include "fetch_defs.svh"

module fetch_buffer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   fetch_valid,
  input  logic                   fetch_fence,
  input  logic [31:0]            fetch_addr,
  output logic                   fetch_ready,
  output fetch_pkg::fetch_word_t fetch_rdata,
  output logic                   imem_valid,
  output logic                   imem_fence,
  output logic [31:0]            imem_addr,
  input  logic                   imem_ready,
  input  fetch_pkg::fetch_word_t imem_rdata
);
  import fetch_pkg::*;

  logic                 wen;
  logic [`FB_DEPTH-1:0] waddr;
  fb_entry_t            wentry;
  logic [`FB_DEPTH-1:0] raddr1;
  logic [`FB_DEPTH-1:0] raddr2;
  fb_entry_t            rentry1;
  fb_entry_t            rentry2;

  fetch_buffer_ram i_fetch_buffer_ram (
    .clk     (clk),
    .wen     (wen),
    .waddr   (waddr),
    .wentry  (wentry),
    .raddr1  (raddr1),
    .raddr2  (raddr2),
    .rentry1 (rentry1),
    .rentry2 (rentry2)
  );

  fetch_buffer_ctrl i_fetch_buffer_ctrl (
    .clk         (clk),
    .rst         (rst),
    .fetch_valid (fetch_valid),
    .fetch_fence (fetch_fence),
    .fetch_addr  (fetch_addr),
    .fetch_ready (fetch_ready),
    .fetch_rdata (fetch_rdata),
    .imem_ready  (imem_ready),
    .imem_rdata  (imem_rdata),
    .imem_valid  (imem_valid),
    .imem_fence  (imem_fence),
    .imem_addr   (imem_addr),
    .wen         (wen),
    .waddr       (waddr),
    .wentry      (wentry),
    .raddr1      (raddr1),
    .raddr2      (raddr2),
    .rentry1     (rentry1),
    .rentry2     (rentry2)
  );

endmodule

//--- tests/imem_model.sv
`timescale 1ns/100ps

module imem_model (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   imem_valid,
  input  fetch_pkg::fetch_word_t mem_data,   // Word at the current imem_addr
  output logic                   imem_ready,
  output fetch_pkg::fetch_word_t imem_rdata
);
  import fetch_pkg::*;

  logic [1:0] wait_cnt;  // Wait states left before the next answer
  logic       took;
  logic       stalled;

  always @(posedge clk) begin
    took    <= imem_valid && imem_ready;
    stalled <= imem_valid && !imem_ready;
  end

  // ############################################################
  // Wait states, a new random count after every accepted word
  // ############################################################

  always @(negedge clk) begin
    if (!rst || took) begin
      wait_cnt = 2'($urandom % 4);
    end else if (stalled && wait_cnt != 2'd0) begin
      wait_cnt = wait_cnt - 2'd1;
    end
  end

  assign imem_ready = rst && imem_valid && (wait_cnt == 2'd0);
  assign imem_rdata = imem_ready ? mem_data : '0;

endmodule

//--- tests/tb_fetch_buffer.sv
`timescale 1ns/100ps
`include "fetch_defs.svh"

module tb_fetch_buffer;
  import fetch_pkg::*;

  localparam int IDLE_CYCLES = 64;
  localparam int N_SEQ     = 120;
  localparam int N_SPLIT   = 24;
  localparam int N_JUMP    = 40;
  localparam int JUMP_RUN  = 4;
  localparam int N_FENCE   = 4;
  localparam int FENCE_RUN = 8;
  localparam int N_REQ = N_SEQ + N_SPLIT + N_JUMP * JUMP_RUN + N_FENCE * (2 * FENCE_RUN + 1);
  localparam int LIMIT = 16 + IDLE_CYCLES + N_REQ * 64 + N_FENCE * ((1 << `FB_DEPTH) + 8);

  logic        clk;
  logic        rst;
  logic        fetch_valid;
  logic        fetch_fence;
  logic [31:0] fetch_addr;
  logic        fetch_ready;
  fetch_word_t fetch_rdata;
  logic        imem_valid;
  logic        imem_fence;
  logic [31:0] imem_addr;
  logic        imem_ready;
  fetch_word_t imem_rdata;
  int          gen;                // Memory content generation
  logic        addr_hold = 1'b0;
  logic [31:0] addr_held = '0;

  fetch_buffer i_fetch_buffer (
    .clk         (clk),
    .rst         (rst),
    .fetch_valid (fetch_valid),
    .fetch_fence (fetch_fence),
    .fetch_addr  (fetch_addr),
    .fetch_ready (fetch_ready),
    .fetch_rdata (fetch_rdata),
    .imem_valid  (imem_valid),
    .imem_fence  (imem_fence),
    .imem_addr   (imem_addr),
    .imem_ready  (imem_ready),
    .imem_rdata  (imem_rdata)
  );

  imem_model i_imem_model (
    .clk        (clk),
    .rst        (rst),
    .imem_valid (imem_valid),
    .mem_data   (mem_word(imem_addr[31:2], gen)),
    .imem_ready (imem_ready),
    .imem_rdata (imem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ############################################################
  // Reference model
  // ############################################################

  // Hash of word address and generation with well mixed length bits
  function automatic fetch_word_t mem_word(input logic [29:0] waddr, input int g);
    logic [31:0] x;
    x = {2'b00, waddr} * 32'h9e37_79b1 + 32'(g) * 32'h7f4a_7c15;
    x = x ^ (x >> 15);
    x = x * 32'h2c1b_3c6d;
    x = x ^ (x >> 13);
    return x;
  endfunction

  function automatic ilen_e parcel_len(input logic [15:0] parcel);
    return (parcel[1:0] == 2'b11) ? ILEN_32 : ILEN_16;
  endfunction

  function automatic fetch_word_t expect_fetch(input logic [31:0] a, input int g);
    fetch_word_t lo;
    fetch_word_t hi;
    lo = mem_word(a[31:2], g);
    hi = mem_word(a[31:2] + 30'd1, g);
    return a[1] ? {hi[15:0], lo[31:16]} : lo;  // Misaligned joins two halves
  endfunction

  // ############################################################
  // Checks
  // ############################################################

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_rdata(input fetch_word_t exp, input fetch_word_t act,
                             input fetch_word_t mask);
    if (((exp ^ act) & mask) != '0) begin
      stop_run($sformatf("ERROR fetch_rdata at %h expected %h got %h mask %h",
                         fetch_addr, exp, act, mask));
    end
  endtask

  task automatic check_imem_addr(input logic [31:0] exp, input logic [31:0] act);
    if (exp != act) begin
      stop_run($sformatf("ERROR imem_addr expected %h got %h", exp, act));
    end
  endtask

  task automatic check_imem_valid(input logic exp, input logic act);
    if (exp !== act) begin
      stop_run($sformatf("ERROR imem_valid expected %h got %h", exp, act));
    end
  endtask

  task automatic check_flush(input logic fence_seen, input logic ready_seen);
    if (!fence_seen) begin
      stop_run("Flush: imem_fence went low before every slot was cleared");
    end else if (ready_seen) begin
      stop_run("Flush: fetch_ready was high while the buffer was flushing");
    end
  endtask

  always @(posedge clk) begin : compare
    fetch_word_t exp;
    if (rst && fetch_valid && !fetch_fence && fetch_ready) begin
      exp = expect_fetch(fetch_addr, gen);
      // Upper half of a 16-bit instruction is don't care
      check_rdata(exp, fetch_rdata,
                  (parcel_len(exp[15:0]) == ILEN_16) ? 32'h0000_ffff : 32'hffff_ffff);
    end
  end

  always @(posedge clk) begin
    if (rst && addr_hold) begin
      check_imem_addr(addr_held, imem_addr);
    end
    addr_hold = rst && imem_valid && !imem_ready;
    addr_held = imem_addr;
  end

  initial begin
    repeat (LIMIT) @(posedge clk);
    stop_run($sformatf("Watchdog: test did not end within %0d cycles", LIMIT));
  end

  // ############################################################
  // Stimulus
  // ############################################################

  // Idle core lets the prefetch run until the window is full
  task automatic idle_prefetch();
    int words;
    words = 0;
    repeat (IDLE_CYCLES) begin
      @(posedge clk);
      check_imem_valid(words < `FB_WINDOW / 2, imem_valid);
      if (imem_valid && imem_ready) begin
        words++;
      end
    end
  endtask

  task automatic fetch_at(input logic [31:0] a, output fetch_word_t got);
    @(negedge clk);
    fetch_valid = 1'b1;
    fetch_fence = 1'b0;
    fetch_addr  = a;
    do begin
      @(posedge clk);
    end while (!fetch_ready);
    got = fetch_rdata;
  endtask

  task automatic run_seq(input logic [31:0] start, input int n);
    logic [31:0] a;
    fetch_word_t got;
    a = start;
    repeat (n) begin
      fetch_at(a, got);
      a = a + ((parcel_len(got[15:0]) == ILEN_32) ? 32'd4 : 32'd2);
    end
  endtask

  // Misaligned start whose parcel is a 32-bit instruction
  task automatic split_fetch();
    logic [31:0] a;
    fetch_word_t w;
    fetch_word_t got;
    a = ($urandom & 32'h000f_fffc) | 32'h2;
    w = mem_word(a[31:2], gen);
    while (parcel_len(w[31:16]) != ILEN_32) begin
      a = a + 32'd4;
      w = mem_word(a[31:2], gen);
    end
    fetch_at(a, got);
  endtask

  // Fence with new memory contents and a fetch held through the flush
  task automatic fence_and_fetch(input logic [31:0] a);
    int n;
    @(negedge clk);
    gen         = gen + 1;
    fetch_valid = 1'b1;
    fetch_fence = 1'b1;
    @(negedge clk);
    fetch_fence = 1'b0;
    fetch_addr  = a;
    for (n = 0; n < (1 << `FB_DEPTH); n++) begin
      @(posedge clk);
      check_flush(imem_fence, fetch_ready);
    end
    do begin
      @(posedge clk);
      if (imem_fence) begin
        check_flush(imem_fence, fetch_ready);
      end
    end while (!fetch_ready);
  endtask

  initial begin
    logic [31:0] a;
    void'($urandom(10557));
    rst         = 1'b0;
    fetch_valid = 1'b0;
    fetch_fence = 1'b0;
    fetch_addr  = '0;
    gen         = 0;
    repeat (16) @(negedge clk);
    rst = 1'b1;

    idle_prefetch();
    run_seq(32'h0, N_SEQ);
    repeat (N_SPLIT) split_fetch();
    repeat (N_JUMP) run_seq($urandom & 32'h00ff_fffe, JUMP_RUN);
    repeat (N_FENCE) begin
      a = $urandom & 32'h00ff_fffe;
      run_seq(a, FENCE_RUN);       // Old generation now in the store
      fence_and_fetch(a);
      run_seq(a, FENCE_RUN);
    end

    @(negedge clk);
    fetch_valid = 1'b0;
    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- flist.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_buffer_ram.sv
rtl/fetch_buffer_ctrl.sv
rtl/fetch_buffer.sv
tests/imem_model.sv
tests/tb_fetch_buffer.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_fetch_buffer
FLIST     := flist.f
BUILD     := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --timescale 1ns/100ps
PASS_MSG  := TESTS PASSED

SIM := $(BUILD)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(wildcard rtl/*.sv rtl/*.svh tests/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)

# The simulator exit code is ignored, the pass line decides
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
